// ==== phys_regfile.f ====
+incdir+include
hdl/prf_types_pkg.sv
hdl/prf_instr_pkg.sv
hdl/toggle_memory_set.sv
hdl/register_bank.sv
hdl/register_file.sv
hdl/instr_decode.sv
hdl/exec_units.sv
hdl/result_commit.sv
hdl/prf_core_top.sv
tests/tb_prf_core.sv

// ==== Makefile ====
# Verilator simulation of the physical register file core
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_prf_core
FILELIST  ?= phys_regfile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= all tests passed

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/tb_prf_core.sv ====
// Testbench for the renamed-register core back end
// Renames as it goes with its own free list, predicts every commit from a
// register model and checks the result ports, ALU commit timing and
// multiplier back-pressure. Random stimulus comes from a Galois LFSR.

`include "prf_defines.svh"

module tb_prf_core
    import prf_types_pkg::*;
    import prf_instr_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int LIVE_MAX   = 40;
    localparam int WAIT_LIMIT = 200;
    localparam int NUM_RANDOM = 300;

    // Expected commit queued per group at the handshake
    typedef struct packed {
        logic [15:0] idx;
        phys_addr_t  rd;
        data_t       value;
        phys_addr_t  rs1;
        phys_addr_t  rs2;
        logic        use_rs2;
        logic        fast;
        logic [31:0] accept_cycle;
    } expect_t;

    logic           clk;
    logic           rst_n;
    instr_t         instr;
    logic           instr_valid;
    logic           instr_ready;
    commit_packet_t result [`PRF_NUM_GROUPS];

    expect_t    alu_q [$];
    expect_t    mul_q [$];
    phys_addr_t live_q [$];

    // Register model with program order values and producing group
    data_t      reg_val [`PRF_NUM_REGS];
    wb_group_t  reg_grp [`PRF_NUM_REGS];
    logic       reg_done [`PRF_NUM_REGS];
    logic       reg_live [`PRF_NUM_REGS];
    int         reg_readers [`PRF_NUM_REGS];
    int         commit_cycle [1024];

    logic [31:0] lfsr;
    int          cycle;
    int          checks;
    int          errors;
    int          timeouts;
    int          num_sent;
    int          num_commits;
    int          alloc_ptr;
    logic        first_xfer;
    logic        aborted;

    prf_core_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .result      (result)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle++;
    end

    ////////////////////
    // Random bits and expected results
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        // Taps 32, 22, 2, 1
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic data_t predict_result(input op_t op, input data_t a, input data_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_XOR:  return a ^ b;
            default: return a * b;
        endcase
    endfunction

    // Mostly recent destinations and sometimes register 0
    function automatic phys_addr_t pick_source();
        int back;
        if (rand_bits(3) == 0 || live_q.size() == 0) begin
            return '0;
        end
        back = int'(rand_bits(3));
        if (back >= live_q.size()) begin
            back = live_q.size() - 1;
        end
        return live_q[live_q.size() - 1 - back];
    endfunction

    ////////////////////
    // Checks
    task automatic check_equal(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            $display("mismatch at %0t: %s expected %0h actual %0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("error at %0t: %s", $time, what);
        end
    endtask

    task automatic take_commit(input int g);
        expect_t e;
        int      pending;
        pending = (g == 0) ? alu_q.size() : mul_q.size();
        check_true(pending > 0, $sformatf("commit on result[%0d] with nothing outstanding", g));
        if (pending == 0) begin
            return;
        end
        e = (g == 0) ? alu_q.pop_front() : mul_q.pop_front();
        check_equal($sformatf("result[%0d].phys_addr", g), 64'(e.rd),
                    64'(result[g].phys_addr));
        check_equal($sformatf("result[%0d].data", g), 64'(e.value), 64'(result[g].data));
        // Independent ALU op commits on the edge after its accept edge
        if (e.fast) begin
            check_equal("alu commit cycle", 64'(e.accept_cycle + 32'd1), 64'(cycle));
        end
        reg_readers[e.rs1]--;
        if (e.use_rs2) begin
            reg_readers[e.rs2]--;
        end
        reg_done[e.rd] = 1'b1;
        commit_cycle[e.idx] = cycle;
        num_commits++;
    endtask

    // Commit monitor sampling at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (!first_xfer) begin
                check_equal("instr_ready", 64'(1), 64'(instr_ready));
                check_equal("result[0].valid", 64'(0), 64'(result[0].valid));
                check_equal("result[1].valid", 64'(0), 64'(result[1].valid));
            end
            for (int g = 0; g < `PRF_NUM_GROUPS; g++) begin
                if (result[g].valid) begin
                    take_commit(g);
                end
            end
        end
    end

    ////////////////////
    // Renaming and driving
    task automatic alloc_reg(output phys_addr_t rd);
        int         tries;
        int         r;
        logic       found;
        phys_addr_t old;
        rd    = '0;
        found = 1'b0;
        tries = 0;
        while (!found && !aborted) begin
            for (int k = 0; k < `PRF_NUM_REGS - 1 && !found; k++) begin
                r = alloc_ptr;
                alloc_ptr = (alloc_ptr % (`PRF_NUM_REGS - 1)) + 1;
                if (!reg_live[r] && reg_done[r] && reg_readers[r] == 0) begin
                    found = 1'b1;
                    rd    = phys_addr_t'(r);
                end
            end
            if (!found) begin
                tries++;
                if (tries > WAIT_LIMIT) begin
                    timeouts++;
                    aborted = 1'b1;
                    $display("timeout waiting for a free physical register at %0t", $time);
                end else begin
                    @(posedge clk);
                    #1;
                end
            end
        end
        if (found) begin
            reg_live[rd] = 1'b1;
            reg_done[rd] = 1'b0;
            live_q.push_back(rd);
            if (live_q.size() > LIVE_MAX) begin
                old = live_q.pop_front();
                reg_live[old] = 1'b0;
            end
        end
    endtask

    // Starts and ends 1 ns after a rising edge
    task automatic run_instr(input op_t op, input phys_addr_t rs1, input phys_addr_t rs2,
                             input logic use_imm, input data_t imm, input logic fast,
                             output phys_addr_t rd, output int idx, output int stall);
        expect_t e;
        data_t   b;
        rd    = '0;
        idx   = num_sent;
        stall = 0;
        if (aborted) begin
            return;
        end
        alloc_reg(rd);
        if (aborted) begin
            return;
        end
        b              = use_imm ? imm : reg_val[rs2];
        e.idx          = 16'(num_sent);
        e.rd           = rd;
        e.value        = predict_result(op, reg_val[rs1], b);
        e.rs1          = rs1;
        e.rs2          = use_imm ? '0 : rs2;
        e.use_rs2      = !use_imm;
        e.fast         = fast;
        e.accept_cycle = '0;
        reg_readers[e.rs1]++;
        if (e.use_rs2) begin
            reg_readers[e.rs2]++;
        end
        instr.op        = op;
        instr.use_imm   = use_imm;
        instr.imm       = use_imm ? imm : '0;
        instr.phys_rd   = rd;
        instr.phys_rs1  = rs1;
        instr.phys_rs2  = e.rs2;
        instr.rs1_group = reg_grp[rs1];
        instr.rs2_group = reg_grp[e.rs2];
        reg_val[rd]     = e.value;
        reg_grp[rd]     = (op == OP_MUL) ? 1'b1 : 1'b0;
        instr_valid     = 1'b1;
        @(negedge clk);
        while (!instr_ready) begin
            stall++;
            if (stall > WAIT_LIMIT) begin
                timeouts++;
                aborted     = 1'b1;
                instr_valid = 1'b0;
                $display("timeout waiting for instr_ready at %0t", $time);
                return;
            end
            @(negedge clk);
        end
        // Back to back independent ALU ops refill the slot as it issues
        if (fast) begin
            check_equal("instr_ready wait cycles", 64'(0), 64'(stall));
        end
        // Transfer lands on the coming edge
        e.accept_cycle = 32'(cycle + 1);
        first_xfer     = 1'b1;
        if (op == OP_MUL) begin
            mul_q.push_back(e);
        end else begin
            alu_q.push_back(e);
        end
        num_sent++;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (!aborted && (alu_q.size() != 0 || mul_q.size() != 0)) begin
            n++;
            if (n > WAIT_LIMIT) begin
                timeouts++;
                aborted = 1'b1;
                $display("timeout waiting for outstanding commits at %0t", $time);
            end else begin
                @(posedge clk);
                #1;
            end
        end
        // Quiet cycles let in-use bits clear and stray commits show up
        repeat (3) begin
            @(posedge clk);
            #1;
        end
    endtask

    ////////////////////
    // Directed sequences
    task automatic directed_tests();
        phys_addr_t ra, rb, rc, r4, tmp;
        phys_addr_t t1, t2, t3, t4, p1, p2, q1, q2;
        int         idx, stall, i_m3, i_x1, i_x2;
        // Immediate forms from register 0 sent back to back
        run_instr(OP_ADD, 0, 0, 1'b1, 32'h1234_5678, 1'b1, ra, idx, stall);
        run_instr(OP_SUB, 0, 0, 1'b1, 32'h0000_0f0f, 1'b1, rb, idx, stall);
        run_instr(OP_XOR, 0, 0, 1'b1, 32'ha5a5_5a5a, 1'b1, rc, idx, stall);
        run_instr(OP_ADD, 0, 0, 1'b1, 32'h0000_0007, 1'b1, r4, idx, stall);
        drain();
        // Independent register forms
        run_instr(OP_ADD, ra, rb, 1'b0, '0, 1'b1, tmp, idx, stall);
        run_instr(OP_SUB, rc, ra, 1'b0, '0, 1'b1, tmp, idx, stall);
        run_instr(OP_XOR, rb, r4, 1'b0, '0, 1'b1, tmp, idx, stall);
        run_instr(OP_SUB, r4, 0, 1'b1, 32'h0000_0010, 1'b1, tmp, idx, stall);
        run_instr(OP_XOR, ra, ra, 1'b0, '0, 1'b1, tmp, idx, stall);
        drain();
        // Second multiply waits in the slot and blocks the stream
        run_instr(OP_MUL, ra, rb, 1'b0, '0, 1'b0, tmp, idx, stall);
        run_instr(OP_MUL, rc, r4, 1'b0, '0, 1'b0, tmp, idx, stall);
        run_instr(OP_ADD, ra, rc, 1'b0, '0, 1'b0, tmp, idx, stall);
        check_true(aborted || stall > 0, "instr_ready stayed high behind a waiting multiply");
        drain();
        // ALU ops overtake a multiply in flight
        run_instr(OP_MUL, ra, r4, 1'b0, '0, 1'b0, tmp, i_m3, stall);
        run_instr(OP_XOR, rb, rc, 1'b0, '0, 1'b0, tmp, i_x1, stall);
        run_instr(OP_SUB, rc, 0, 1'b1, 32'h0000_0100, 1'b0, tmp, i_x2, stall);
        drain();
        check_true(aborted || commit_cycle[i_x1] < commit_cycle[i_m3],
                   "first ALU op did not commit before the multiply");
        check_true(aborted || commit_cycle[i_x2] < commit_cycle[i_m3],
                   "second ALU op did not commit before the multiply");
        // Dependent chains through the bypass
        run_instr(OP_ADD, ra, rb, 1'b0, '0, 1'b0, t1, idx, stall);
        run_instr(OP_SUB, t1, rc, 1'b0, '0, 1'b0, t2, idx, stall);
        run_instr(OP_XOR, t2, t1, 1'b0, '0, 1'b0, t3, idx, stall);
        run_instr(OP_ADD, t3, 0, 1'b1, 32'h0000_1000, 1'b0, t4, idx, stall);
        run_instr(OP_MUL, t4, r4, 1'b0, '0, 1'b0, p1, idx, stall);
        run_instr(OP_ADD, p1, ra, 1'b0, '0, 1'b0, q1, idx, stall);
        run_instr(OP_MUL, q1, p1, 1'b0, '0, 1'b0, p2, idx, stall);
        run_instr(OP_XOR, p2, t4, 1'b0, '0, 1'b0, q2, idx, stall);
        run_instr(OP_MUL, q2, 0, 1'b1, 32'h0000_0003, 1'b0, tmp, idx, stall);
        drain();
    endtask

    task automatic random_stream(input int count);
        phys_addr_t rs1, rs2, dst;
        logic [1:0] op_bits;
        logic       use_imm;
        data_t      imm;
        int         idx, stall;
        for (int n = 0; n < count && !aborted; n++) begin
            op_bits = 2'(rand_bits(2));
            use_imm = (rand_bits(1) != 0);
            imm     = rand_bits(32);
            rs1     = pick_source();
            rs2     = use_imm ? '0 : pick_source();
            run_instr(op_t'(op_bits), rs1, rs2, use_imm, imm, 1'b0, dst, idx, stall);
            // Occasional idle cycle on the stream
            if (rand_bits(2) == 0) begin
                @(posedge clk);
                #1;
            end
        end
        drain();
    endtask

    task automatic finish_run();
        $display("checks=%0d errors=%0d timeouts=%0d sent=%0d commits=%0d",
                 checks, errors, timeouts, num_sent, num_commits);
        if (errors == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    initial begin
        lfsr        = 32'd10;
        cycle       = 0;
        checks      = 0;
        errors      = 0;
        timeouts    = 0;
        num_sent    = 0;
        num_commits = 0;
        alloc_ptr   = 1;
        first_xfer  = 1'b0;
        aborted     = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        for (int r = 0; r < `PRF_NUM_REGS; r++) begin
            reg_val[r]     = '0;
            reg_grp[r]     = '0;
            reg_done[r]    = 1'b1;
            reg_live[r]    = 1'b0;
            reg_readers[r] = 0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Idle while the monitor watches ready and the result valids
        repeat (4) begin
            @(posedge clk);
            #1;
        end
        directed_tests();
        random_stream(NUM_RANDOM);
        finish_run();
    end

endmodule

// ==== hdl/prf_core_top.sv ====
// Renamed-register core back end
// Decode and issue slot, physical register file, ALU and multiplier,
// and the commit stage whose packets double as the result ports.

`include "prf_defines.svh"

module prf_core_top
    import prf_types_pkg::*;
    import prf_instr_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  instr_t         instr,
    input  logic           instr_valid,
    output logic           instr_ready,
    output commit_packet_t result [`PRF_NUM_GROUPS]
);

    logic           decode_advance;
    phys_addr_t     decode_rd;
    phys_addr_t     decode_rs [2];
    wb_group_t      decode_rs_group [2];
    phys_addr_t     slot_rs [2];
    wb_group_t      slot_rs_group [2];
    logic [1:0]     src_inuse;
    data_t          operand [2];
    issue_packet_t  issue;
    logic           mul_busy;
    commit_packet_t alu_out;
    commit_packet_t mul_out;
    commit_packet_t commit [`PRF_NUM_GROUPS];

    instr_decode i_decode (
        .clk             (clk),
        .rst_n           (rst_n),
        .instr           (instr),
        .instr_valid     (instr_valid),
        .instr_ready     (instr_ready),
        .src_inuse       (src_inuse),
        .operand         (operand),
        .mul_busy        (mul_busy),
        .decode_advance  (decode_advance),
        .decode_rd       (decode_rd),
        .decode_rs       (decode_rs),
        .decode_rs_group (decode_rs_group),
        .slot_rs         (slot_rs),
        .slot_rs_group   (slot_rs_group),
        .issue           (issue)
    );

    register_file i_regfile (
        .clk             (clk),
        .rst_n           (rst_n),
        .decode_advance  (decode_advance),
        .decode_rd       (decode_rd),
        .decode_rs       (decode_rs),
        .decode_rs_group (decode_rs_group),
        .slot_rs         (slot_rs),
        .slot_rs_group   (slot_rs_group),
        .commit          (commit),
        .src_inuse       (src_inuse),
        .operand         (operand)
    );

    exec_units i_exec (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue    (issue),
        .mul_busy (mul_busy),
        .alu_out  (alu_out),
        .mul_out  (mul_out)
    );

    result_commit i_commit (
        .clk     (clk),
        .rst_n   (rst_n),
        .alu_out (alu_out),
        .mul_out (mul_out),
        .commit  (commit)
    );

    // Commit packets are the external result ports
    assign result = commit;

endmodule

// ==== hdl/result_commit.sv ====
// Result stage
// Registers each unit's result into its group's commit packet. Writes to
// register 0 are dropped here so it is never written or marked free.

`include "prf_defines.svh"

module result_commit
    import prf_types_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  commit_packet_t alu_out,
    input  commit_packet_t mul_out,
    output commit_packet_t commit [`PRF_NUM_GROUPS]
);

    // Group order, ALU first
    commit_packet_t unit_out [`PRF_NUM_GROUPS];

    assign unit_out[0] = alu_out;
    assign unit_out[1] = mul_out;

    always_ff @(posedge clk) begin
        for (int g = 0; g < `PRF_NUM_GROUPS; g++) begin
            if (!rst_n) begin
                commit[g].valid <= 1'b0;
            end else begin
                commit[g].valid <= unit_out[g].valid && (unit_out[g].phys_addr != '0);
            end
            // Payload follows the unit every cycle
            commit[g].phys_addr <= unit_out[g].phys_addr;
            commit[g].data      <= unit_out[g].data;
        end
    end

endmodule

// ==== hdl/exec_units.sv ====
// Execution units
// Combinational ALU for add, subtract and exclusive OR, plus an iterative
// shift-add multiplier returning the low word after PRF_MUL_CYCLES steps.
// Both hand unregistered results to the commit stage.

`include "prf_defines.svh"

module exec_units
    import prf_types_pkg::*;
    import prf_instr_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  issue_packet_t  issue,
    output logic           mul_busy,
    output commit_packet_t alu_out,
    output commit_packet_t mul_out
);

    // Multiplier bits consumed per step
    localparam int STEP_W = `PRF_DATA_W / `PRF_MUL_CYCLES;
    localparam int CNT_W  = $clog2(`PRF_MUL_CYCLES);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`PRF_MUL_CYCLES - 1);

    logic             mul_start;
    logic             mul_last;
    logic [CNT_W-1:0] step_cnt;
    data_t            acc;
    data_t            mcand;
    data_t            mplier;
    phys_addr_t       mul_rd;
    data_t            src_acc;
    data_t            src_mcand;
    data_t            src_mplier;
    data_t            step_sum;

    ////////////////////
    // ALU
    always_comb begin
        alu_out.valid     = issue.valid && (issue.op != OP_MUL);
        alu_out.phys_addr = issue.phys_rd;
        case (issue.op)
            OP_SUB:  alu_out.data = issue.operand_a - issue.operand_b;
            OP_XOR:  alu_out.data = issue.operand_a ^ issue.operand_b;
            default: alu_out.data = issue.operand_a + issue.operand_b;
        endcase
    end

    ////////////////////
    // Multiplier
    // First step runs on the issue edge, the last one feeds mul_out directly
    assign mul_start = issue.valid && (issue.op == OP_MUL);
    assign mul_last  = mul_busy && (step_cnt == LAST_STEP);

    always_comb begin
        src_acc    = mul_start ? '0 : acc;
        src_mcand  = mul_start ? issue.operand_a : mcand;
        src_mplier = mul_start ? issue.operand_b : mplier;
        step_sum   = src_acc;
        // Shift-add over the low bits of the multiplier
        for (int j = 0; j < STEP_W; j++) begin
            if (src_mplier[j]) begin
                step_sum = step_sum + (src_mcand << j);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mul_busy <= 1'b0;
            step_cnt <= '0;
        end else if (mul_start) begin
            mul_busy <= 1'b1;
            step_cnt <= CNT_W'(1);
        end else if (mul_last) begin
            mul_busy <= 1'b0;
        end else if (mul_busy) begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    // Partial product and shifted operands
    always_ff @(posedge clk) begin
        if (mul_start || mul_busy) begin
            acc    <= step_sum;
            mcand  <= src_mcand << STEP_W;
            mplier <= src_mplier >> STEP_W;
        end
        if (mul_start) begin
            mul_rd <= issue.phys_rd;
        end
    end

    // Valid for the single cycle of the last step
    always_comb begin
        mul_out.valid     = mul_last;
        mul_out.phys_addr = mul_rd;
        mul_out.data      = step_sum;
    end

endmodule

// ==== hdl/instr_decode.sv ====
// Decode stage and single issue slot
// Accepts one renamed instruction into the slot, holds it until both
// sources are free and the target unit can take it, then issues it.

module instr_decode
    import prf_types_pkg::*;
    import prf_instr_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  instr_t        instr,
    input  logic          instr_valid,
    output logic          instr_ready,
    input  logic [1:0]    src_inuse,
    input  data_t         operand [2],
    input  logic          mul_busy,
    output logic          decode_advance,
    output phys_addr_t    decode_rd,
    output phys_addr_t    decode_rs [2],
    output wb_group_t     decode_rs_group [2],
    output phys_addr_t    slot_rs [2],
    output wb_group_t     slot_rs_group [2],
    output issue_packet_t issue
);

    slot_state_t state;
    instr_t      slot;
    logic        srcs_ready;
    logic        unit_free;
    logic        slot_issue;

    ////////////////////
    // Issue decision
    // rs2 is ignored for immediate forms
    assign srcs_ready = !src_inuse[0] && (slot.use_imm || !src_inuse[1]);
    // Only the multiplier can stall
    assign unit_free  = (slot.op != OP_MUL) || !mul_busy;
    assign slot_issue = (state == SLOT_WAIT) && srcs_ready && unit_free;

    // Refill in the same cycle the slot drains
    assign instr_ready    = (state == SLOT_EMPTY) || slot_issue;
    assign decode_advance = instr_valid && instr_ready;

    // Decode side addresses
    assign decode_rd          = instr.phys_rd;
    assign decode_rs[0]       = instr.phys_rs1;
    assign decode_rs[1]       = instr.phys_rs2;
    assign decode_rs_group[0] = instr.rs1_group;
    assign decode_rs_group[1] = instr.rs2_group;

    // Slot side addresses
    assign slot_rs[0]       = slot.phys_rs1;
    assign slot_rs[1]       = slot.phys_rs2;
    assign slot_rs_group[0] = slot.rs1_group;
    assign slot_rs_group[1] = slot.rs2_group;

    ////////////////////
    // Slot FSM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= SLOT_EMPTY;
        end else if (decode_advance) begin
            state <= SLOT_WAIT;
        end else if (slot_issue) begin
            state <= SLOT_EMPTY;
        end
    end

    always_ff @(posedge clk) begin
        if (decode_advance) begin
            slot <= instr;
        end
    end

    // Issue packet, immediate replaces operand b
    always_comb begin
        issue.valid     = slot_issue;
        issue.op        = slot.op;
        issue.phys_rd   = slot.phys_rd;
        issue.operand_a = operand[0];
        issue.operand_b = slot.use_imm ? slot.imm : operand[1];
    end

endmodule

// ==== hdl/register_file.sv ====
// Physical register file
// One bank per writeback group, in-use tracking over toggle banks, and the
// registered operands of the issue slot. Operands load at decode, taking the
// commit bus when the source is written in that cycle, and reload from the
// commit bus while the source is still in use.

`include "prf_defines.svh"

module register_file
    import prf_types_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           decode_advance,
    input  phys_addr_t     decode_rd,
    input  phys_addr_t     decode_rs [2],
    input  wb_group_t      decode_rs_group [2],
    input  phys_addr_t     slot_rs [2],
    input  wb_group_t      slot_rs_group [2],
    input  commit_packet_t commit [`PRF_NUM_GROUPS],
    output logic [1:0]     src_inuse,
    output data_t          operand [2]
);

    data_t      bank_data [`PRF_NUM_GROUPS][2];
    phys_addr_t rs_addr [2];
    wb_group_t  rs_group [2];
    logic [1:0] rs_commit_hit;

    ////////////////////
    // In-use tracking
    // Set on decode of a non-zero rd, cleared by that group's commit
    toggle_memory_set #(
        .NUM_TOGGLE (3),
        .NUM_READ   (2)
    ) i_inuse (
        .clk         (clk),
        .rst_n       (rst_n),
        .toggle      ({commit[1].valid, commit[0].valid, decode_advance & (|decode_rd)}),
        .toggle_addr ('{decode_rd, commit[0].phys_addr, commit[1].phys_addr}),
        .read_addr   (slot_rs),
        .in_use      (src_inuse)
    );

    ////////////////////
    // Register banks
    for (genvar g = 0; g < `PRF_NUM_GROUPS; g++) begin : g_bank
        register_bank #(
            .NUM_READ (2)
        ) i_bank (
            .clk        (clk),
            .write_en   (commit[g].valid),
            .write_addr (commit[g].phys_addr),
            .write_data (commit[g].data),
            .read_addr  (decode_rs),
            .read_data  (bank_data[g])
        );
    end

    ////////////////////
    // Operand muxing
    // Decode sources take priority, otherwise watch the slot sources
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rs_addr[i]       = decode_advance ? decode_rs[i] : slot_rs[i];
            rs_group[i]      = decode_advance ? decode_rs_group[i] : slot_rs_group[i];
            rs_commit_hit[i] = commit[rs_group[i]].valid &&
                               (commit[rs_group[i]].phys_addr == rs_addr[i]);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (decode_advance) begin
                // Bank write lands on this edge, so bypass it
                operand[i] <= rs_commit_hit[i] ? commit[rs_group[i]].data
                                               : bank_data[rs_group[i]][i];
            end else if (src_inuse[i] && rs_commit_hit[i]) begin
                operand[i] <= commit[rs_group[i]].data;
            end
        end
    end

endmodule

// ==== hdl/register_bank.sv ====
// Storage for one writeback group
// One write port fed by the group's commit bus, combinational read ports

`include "prf_defines.svh"

module register_bank
    import prf_types_pkg::*;
#(
    parameter int NUM_READ = 2
) (
    input  logic       clk,
    input  logic       write_en,
    input  phys_addr_t write_addr,
    input  data_t      write_data,
    input  phys_addr_t read_addr [NUM_READ],
    output data_t      read_data [NUM_READ]
);

    // Starts at zero so unwritten registers, register 0 included, read 0
    data_t mem [`PRF_NUM_REGS] = '{default: '0};

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[write_addr] <= write_data;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_READ; i++) begin
            read_data[i] = mem[read_addr[i]];
        end
    end

endmodule

// ==== hdl/toggle_memory_set.sv ====
// In-use tracker for the physical registers
// Every toggle port owns one bit bank and flips the bit at its address,
// so all ports may write in the same cycle. A register is in use when
// the exclusive OR of its bits over all banks is one.

`include "prf_defines.svh"

module toggle_memory_set
    import prf_types_pkg::*;
#(
    parameter int NUM_TOGGLE = 3,
    parameter int NUM_READ   = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [NUM_TOGGLE-1:0] toggle,
    input  phys_addr_t            toggle_addr [NUM_TOGGLE],
    input  phys_addr_t            read_addr [NUM_READ],
    output logic [NUM_READ-1:0]   in_use
);

    // One bank per toggle port
    logic [`PRF_NUM_REGS-1:0] bank [NUM_TOGGLE];

    always_ff @(posedge clk) begin
        for (int t = 0; t < NUM_TOGGLE; t++) begin
            if (!rst_n) begin
                bank[t] <= '0;
            end else if (toggle[t]) begin
                bank[t][toggle_addr[t]] <= ~bank[t][toggle_addr[t]];
            end
        end
    end

    // Fold the banks per read port
    always_comb begin
        for (int r = 0; r < NUM_READ; r++) begin
            in_use[r] = 1'b0;
            for (int t = 0; t < NUM_TOGGLE; t++) begin
                in_use[r] = in_use[r] ^ bank[t][read_addr[r]];
            end
        end
    end

endmodule

// ==== hdl/prf_instr_pkg.sv ====
// Instruction-side types for the decode and execute stages
// Opcodes, renamed instruction, issue packet and issue slot states

package prf_instr_pkg;

    import prf_types_pkg::*;

    // MUL goes to group 1, the rest to the ALU
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_XOR = 2'd2,
        OP_MUL = 2'd3
    } op_t;

    // Already renamed instruction
    typedef struct packed {
        op_t        op;
        logic       use_imm;
        data_t      imm;
        phys_addr_t phys_rd;
        phys_addr_t phys_rs1;
        phys_addr_t phys_rs2;
        wb_group_t  rs1_group;
        wb_group_t  rs2_group;
    } instr_t;

    // Slot to execution units
    typedef struct packed {
        logic       valid;
        op_t        op;
        phys_addr_t phys_rd;
        data_t      operand_a;
        data_t      operand_b;
    } issue_packet_t;

    typedef enum logic {
        SLOT_EMPTY = 1'b0,
        SLOT_WAIT  = 1'b1
    } slot_state_t;

endpackage

// ==== hdl/prf_types_pkg.sv ====
// Datapath types shared by the register file and the execution units
// Physical register numbers, data words, writeback groups, commit packets

`include "prf_defines.svh"

package prf_types_pkg;

    // Physical register number
    typedef logic [`PRF_ADDR_W-1:0] phys_addr_t;

    // Data word as held in the banks
    typedef logic [`PRF_DATA_W-1:0] data_t;

    // Writeback group, one per commit port
    typedef logic [$clog2(`PRF_NUM_GROUPS)-1:0] wb_group_t;

    // One group's writeback in one cycle
    typedef struct packed {
        logic       valid;
        phys_addr_t phys_addr;
        data_t      data;
    } commit_packet_t;

endpackage

// ==== include/prf_defines.svh ====
// Physical register file core parameters
// Register count, data width, multiplier latency and writeback groups

`ifndef PRF_DEFINES_SVH
`define PRF_DEFINES_SVH

// Physical registers, register 0 is hardwired to zero
`define PRF_NUM_REGS 64

// Address width for PRF_NUM_REGS entries
`define PRF_ADDR_W 6

// Data word width
`define PRF_DATA_W 32

// Multiplier latency from issue to commit
`define PRF_MUL_CYCLES 4

// Writeback groups, ALU is group 0 and multiplier is group 1
`define PRF_NUM_GROUPS 2

`endif
